// File: design/rv_core_pkg.sv
package rv_core_pkg;

  localparam int XLEN        = 32;
  localparam int IMEM_AWIDTH = 10;  // 1024 instruction words
  localparam int DMEM_AWIDTH = 8;   // 256 data words

  typedef logic [XLEN-1:0]        word_t;
  typedef logic [4:0]             reg_addr_t;
  typedef logic [IMEM_AWIDTH-1:0] imem_addr_t;  // word address, not byte
  typedef logic [DMEM_AWIDTH-1:0] dmem_addr_t;
  typedef logic [3:0]             alu_op_t;

  localparam word_t RESET_PC = 32'h0000_0000;

  // alu codes line up with {inst[30], funct3}
  localparam alu_op_t ALU_ADD  = 4'b0000;
  localparam alu_op_t ALU_SUB  = 4'b1000;
  localparam alu_op_t ALU_AND  = 4'b0111;
  localparam alu_op_t ALU_OR   = 4'b0110;
  localparam alu_op_t ALU_XOR  = 4'b0100;
  localparam alu_op_t ALU_SLL  = 4'b0001;
  localparam alu_op_t ALU_SRL  = 4'b0101;
  localparam alu_op_t ALU_SRA  = 4'b1101;
  localparam alu_op_t ALU_SLT  = 4'b0010;
  localparam alu_op_t ALU_SLTU = 4'b0011;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

endpackage

// File: design/inst_mem.sv
module inst_mem (
  input  logic                    clk,
  input  rv_core_pkg::imem_addr_t rd_addr,
  output rv_core_pkg::word_t      rd_data,
  input  logic                    wr_en,
  input  rv_core_pkg::imem_addr_t wr_addr,
  input  rv_core_pkg::word_t      wr_data
);
  import rv_core_pkg::*;

  word_t mem [2**IMEM_AWIDTH];

  // program load port, usually only used while the core sits in reset
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];  // one cycle fetch latency
  end

endmodule

// File: design/data_mem.sv
module data_mem (
  input  logic                    clk,
  input  rv_core_pkg::dmem_addr_t addr,
  input  logic                    wr_en,
  input  rv_core_pkg::word_t      wr_data,
  output rv_core_pkg::word_t      rd_data
);
  import rv_core_pkg::*;

  word_t mem [2**DMEM_AWIDTH] = '{default: '0};  // unwritten words read zero

  always_ff @(posedge clk) begin
    rd_data <= mem[addr];  // old data on a same-address write
    if (wr_en) begin
      mem[addr] <= wr_data;
    end
  end

  // a store with an X address would corrupt some unknown word
  a_wr_addr_known: assert property (
    @(posedge clk) wr_en |-> !$isunknown(addr)
  ) else $error("data_mem write with unknown address");

endmodule

// File: design/reg_file.sv
module reg_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_core_pkg::reg_addr_t rs1_addr,
  input  rv_core_pkg::reg_addr_t rs2_addr,
  output rv_core_pkg::word_t     rs1_data,
  output rv_core_pkg::word_t     rs2_data,
  input  logic                   wr_en,
  input  rv_core_pkg::reg_addr_t wr_addr,
  input  rv_core_pkg::word_t     wr_data
);
  import rv_core_pkg::*;

  word_t regs [2**$bits(reg_addr_t)];  // regs[0] is never written
  logic  wr_live;

  assign wr_live = wr_en && (wr_addr != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**$bits(reg_addr_t); i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // bypass the write in flight so ID sees the WB result
  assign rs1_data = (wr_live && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
  assign rs2_data = (wr_live && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

  a_wr_data_known: assert property (
    @(posedge clk) disable iff (!rst_n) wr_en |-> !$isunknown(wr_data)
  ) else $error("reg_file write of unknown data to x%0d", wr_addr);

endmodule

// File: design/inst_decode.sv
module inst_decode (
  input  rv_core_pkg::word_t     inst,
  output rv_core_pkg::reg_addr_t rs1_addr,
  output rv_core_pkg::reg_addr_t rs2_addr,
  output rv_core_pkg::reg_addr_t rd_addr,
  output rv_core_pkg::word_t     imm,
  output rv_core_pkg::alu_op_t   alu_op,
  output logic                   alu_src_imm,
  output logic                   reg_we,
  output logic                   mem_read,
  output logic                   mem_write,
  output logic                   mem_to_reg,
  output logic                   is_branch,
  output logic                   branch_ne,
  output logic                   is_jal,
  output logic                   is_lui
);
  import rv_core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_t    arith_op;

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign rd_addr  = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // bit 30 picks sub only for register ops, sra for both forms
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OPC_OP && inst[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = inst[30] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    imm         = '0;
    alu_op      = ALU_ADD;  // address and lui paths add
    alu_src_imm = 1'b0;
    reg_we      = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    mem_to_reg  = 1'b0;
    is_branch   = 1'b0;
    branch_ne   = funct3[0];
    is_jal      = 1'b0;
    is_lui      = 1'b0;
    case (opcode)
      OPC_OP: begin
        alu_op = arith_op;
        reg_we = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_op      = arith_op;
        imm         = imm_i;
        alu_src_imm = 1'b1;
        reg_we      = 1'b1;
      end
      OPC_LUI: begin
        imm         = imm_u;
        alu_src_imm = 1'b1;
        reg_we      = 1'b1;
        is_lui      = 1'b1;
      end
      OPC_LOAD: begin
        imm         = imm_i;
        alu_src_imm = 1'b1;
        reg_we      = 1'b1;
        mem_read    = 1'b1;
        mem_to_reg  = 1'b1;
      end
      OPC_STORE: begin
        imm         = imm_s;
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      OPC_BRANCH: begin
        imm       = imm_b;
        is_branch = (funct3[2:1] == 2'b00);  // beq and bne only
      end
      OPC_JAL: begin
        imm    = imm_j;
        reg_we = 1'b1;
        is_jal = 1'b1;
      end
      default: ;  // anything else is a bubble
    endcase
  end

endmodule

// File: design/alu.sv
module alu (
  input  rv_core_pkg::word_t   a,
  input  rv_core_pkg::word_t   b,
  input  rv_core_pkg::alu_op_t op,
  output rv_core_pkg::word_t   result
);
  import rv_core_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed, lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
      default:  result = '0;
    endcase
  end

endmodule

// File: design/execute_stage.sv
module execute_stage (
  input  rv_core_pkg::word_t      rs1_data,
  input  rv_core_pkg::word_t      rs2_data,
  input  rv_core_pkg::word_t      imm,
  input  rv_core_pkg::word_t      pc,
  input  rv_core_pkg::reg_addr_t  rs1_addr,
  input  rv_core_pkg::reg_addr_t  rs2_addr,
  input  rv_core_pkg::alu_op_t    alu_op,
  input  logic                    alu_src_imm,
  input  logic                    is_branch,
  input  logic                    branch_ne,
  input  logic                    is_jal,
  input  logic                    is_lui,
  input  logic                    mem_write,
  input  logic                    valid,
  input  logic                    fwd_en,
  input  rv_core_pkg::reg_addr_t  fwd_rd,
  input  rv_core_pkg::word_t      fwd_data,
  output rv_core_pkg::word_t      result,
  output logic                    taken,
  output rv_core_pkg::word_t      target,
  output logic                    store_en,
  output rv_core_pkg::dmem_addr_t mem_addr,
  output rv_core_pkg::word_t      store_data
);
  import rv_core_pkg::*;

  word_t src1, src2, op_a, op_b, alu_out;
  logic  fwd_live, equal;

  // WB result overrides the stale ID read, covers load-use too
  assign fwd_live = fwd_en && (fwd_rd != '0);
  assign src1     = (fwd_live && fwd_rd == rs1_addr) ? fwd_data : rs1_data;
  assign src2     = (fwd_live && fwd_rd == rs2_addr) ? fwd_data : rs2_data;

  assign op_a = is_lui ? '0 : src1;  // lui is 0 + imm
  assign op_b = alu_src_imm ? imm : src2;

  alu alu_i (
    .a     (op_a),
    .b     (op_b),
    .op    (alu_op),
    .result(alu_out)
  );

  assign result = is_jal ? pc + word_t'(4) : alu_out;  // link value for jal

  assign equal  = (src1 == src2);
  assign taken  = valid && (is_jal || (is_branch && (equal != branch_ne)));
  assign target = pc + imm;

  assign store_en   = valid && mem_write;
  assign mem_addr   = alu_out[DMEM_AWIDTH+1:2];  // byte address to word index
  assign store_data = src2;

  // misaligned targets would only come from a bad immediate or pc
  always_comb begin
    if (taken) begin
      assert (target[1:0] == 2'b00)
      else $error("taken target %h not word aligned", target);
    end
  end

endmodule

// File: design/rv_core.sv
module rv_core (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    imem_load_en,
  input  rv_core_pkg::imem_addr_t imem_load_addr,
  input  rv_core_pkg::word_t      imem_load_data,
  output logic                    wb_valid,
  output rv_core_pkg::reg_addr_t  wb_rd,
  output rv_core_pkg::word_t      wb_data
);
  import rv_core_pkg::*;

  word_t      pc, pc_next;
  word_t      id_pc, id_inst, id_imm, id_rs1_data, id_rs2_data;
  reg_addr_t  id_rs1_addr, id_rs2_addr, id_rd;
  alu_op_t    id_alu_op;
  logic       id_valid, id_alu_src_imm, id_reg_we, id_mem_write;
  logic       id_mem_to_reg, id_is_branch, id_branch_ne, id_is_jal, id_is_lui;
  word_t      ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
  reg_addr_t  ex_rs1_addr, ex_rs2_addr, ex_rd;
  alu_op_t    ex_alu_op;
  logic       ex_valid, ex_alu_src_imm, ex_reg_we, ex_mem_write;
  logic       ex_mem_to_reg, ex_is_branch, ex_branch_ne, ex_is_jal, ex_is_lui;
  word_t      ex_result, ex_target, ex_store_data;
  logic       ex_taken, ex_store_en;
  dmem_addr_t ex_mem_addr;
  word_t      wb_result, wb_mem_data;
  logic       wb_mem_to_reg;

  assign pc_next = ex_taken ? ex_target : pc + word_t'(4);

  // a redirect from EX kills the two younger slots
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc            <= RESET_PC;
      id_valid      <= 1'b0;
      ex_valid      <= 1'b0;
      wb_valid      <= 1'b0;
      wb_mem_to_reg <= 1'b0;
    end else begin
      pc            <= pc_next;
      id_valid      <= !ex_taken;
      ex_valid      <= id_valid && !ex_taken;
      wb_valid      <= ex_valid && ex_reg_we && (ex_rd != '0);  // x0 writes vanish
      wb_mem_to_reg <= ex_mem_to_reg;
    end
  end

  inst_mem inst_mem_i (
    .clk(clk), .rd_addr(pc[IMEM_AWIDTH+1:2]), .rd_data(id_inst),
    .wr_en(imem_load_en), .wr_addr(imem_load_addr), .wr_data(imem_load_data)
  );

  inst_decode inst_decode_i (
    .inst(id_inst), .rs1_addr(id_rs1_addr), .rs2_addr(id_rs2_addr), .rd_addr(id_rd),
    .imm(id_imm), .alu_op(id_alu_op), .alu_src_imm(id_alu_src_imm), .reg_we(id_reg_we),
    .mem_read(), .mem_write(id_mem_write), .mem_to_reg(id_mem_to_reg),
    .is_branch(id_is_branch), .branch_ne(id_branch_ne), .is_jal(id_is_jal),
    .is_lui(id_is_lui)
  );

  reg_file reg_file_i (
    .clk(clk), .rst_n(rst_n),
    .rs1_addr(id_rs1_addr), .rs2_addr(id_rs2_addr),
    .rs1_data(id_rs1_data), .rs2_data(id_rs2_data),
    .wr_en(wb_valid), .wr_addr(wb_rd), .wr_data(wb_data)
  );

  // payload registers qualified by the valid bits above
  always_ff @(posedge clk) begin
    id_pc <= pc;  // pairs with the instruction word out of inst_mem
    {ex_pc, ex_imm, ex_rs1_data, ex_rs2_data} <= {id_pc, id_imm, id_rs1_data, id_rs2_data};
    {ex_rs1_addr, ex_rs2_addr, ex_rd, ex_alu_op} <= {id_rs1_addr, id_rs2_addr, id_rd, id_alu_op};
    {ex_alu_src_imm, ex_reg_we, ex_mem_write, ex_mem_to_reg} <=
      {id_alu_src_imm, id_reg_we, id_mem_write, id_mem_to_reg};
    {ex_is_branch, ex_branch_ne, ex_is_jal, ex_is_lui} <=
      {id_is_branch, id_branch_ne, id_is_jal, id_is_lui};
    wb_result <= ex_result;
    wb_rd     <= ex_rd;
  end

  execute_stage execute_stage_i (
    .rs1_data(ex_rs1_data), .rs2_data(ex_rs2_data), .imm(ex_imm), .pc(ex_pc),
    .rs1_addr(ex_rs1_addr), .rs2_addr(ex_rs2_addr), .alu_op(ex_alu_op),
    .alu_src_imm(ex_alu_src_imm), .is_branch(ex_is_branch), .branch_ne(ex_branch_ne),
    .is_jal(ex_is_jal), .is_lui(ex_is_lui), .mem_write(ex_mem_write), .valid(ex_valid),
    .fwd_en(wb_valid), .fwd_rd(wb_rd), .fwd_data(wb_data),
    .result(ex_result), .taken(ex_taken), .target(ex_target),
    .store_en(ex_store_en), .mem_addr(ex_mem_addr), .store_data(ex_store_data)
  );

  data_mem data_mem_i (
    .clk(clk), .addr(ex_mem_addr), .wr_en(ex_store_en),
    .wr_data(ex_store_data), .rd_data(wb_mem_data)  // load data lands in WB
  );

  assign wb_data = wb_mem_to_reg ? wb_mem_data : wb_result;

  a_taken_live: assert property (
    @(posedge clk) disable iff (!rst_n) ex_taken |-> ex_valid
  ) else $error("redirect from a squashed EX slot");

endmodule

// File: tb/rv_core_tb.sv
module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_core_pkg::*;

  localparam int PROG_LEN     = 200;
  localparam int RESET_CYCLES = 16;
  localparam int QUIET_CYCLES = 20;
  // load time, reset time, then 8 cycles per program word
  localparam int WATCHDOG_CYCLES = PROG_LEN + 1 + RESET_CYCLES + 8 * PROG_LEN + QUIET_CYCLES;

  logic       clk;
  logic       rst_n;
  logic       imem_load_en;
  imem_addr_t imem_load_addr;
  word_t      imem_load_data;
  logic       wb_valid;
  reg_addr_t  wb_rd;
  word_t      wb_data;

  integer    seed = 86875;
  word_t     prog [PROG_LEN];
  reg_addr_t exp_rd[$];    // expected writebacks in program order
  word_t     exp_data[$];
  int        seen_count = 0;

  rv_core dut_i (
    .clk(clk), .rst_n(rst_n), .imem_load_en(imem_load_en),
    .imem_load_addr(imem_load_addr), .imem_load_data(imem_load_data),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic word_t r_type(logic alt, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};  // sw
  endfunction

  function automatic word_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // integer ops as the ISA defines them
  // alt selects sub or sra
  function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_value(string what, word_t expected, word_t actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %h, actual %h", what, expected, actual);
      abort_run("writeback does not match the instruction-set model");
    end
  endtask

  task automatic build_program();
    int          kind;
    int          step;
    logic        alt;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [11:0] offs;
    reg_addr_t   rd, rs1, rs2;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      kind = rand_below(20);
      rd   = reg_addr_t'(rand_below(8));  // few registers give many dependencies
      rs1  = reg_addr_t'(rand_below(8));
      rs2  = reg_addr_t'(rand_below(8));
      f3   = 3'(rand_below(8));
      step = 1 + rand_below(6);
      if (i + step > PROG_LEN - 1) step = PROG_LEN - 1 - i;
      offs = (rand_below(4) == 0) ? 12'(4 * rand_below(256)) : 12'(4 * rand_below(16));
      if (kind < 8) begin
        alt     = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rand_below(2)) : 1'b0;
        prog[i] = r_type(alt, rs2, rs1, f3, rd);
      end else if (kind < 12) begin
        imm = 12'(rand_below(4096));
        if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
        else if (f3 == 3'd5) imm = {1'b0, imm[10], 5'b0, imm[4:0]};  // srli or srai
        prog[i] = i_type(imm, rs1, f3, rd, OPC_OP_IMM);
      end else if (kind == 12) begin
        prog[i] = u_type(20'(rand_below(1 << 20)), rd);
      end else if (kind < 15) begin
        prog[i] = i_type(offs, 5'd0, 3'b010, rd, OPC_LOAD);
      end else if (kind < 17) begin
        prog[i] = s_type(offs, rs2, 5'd0);
      end else if (kind < 19) begin
        // same register on both sides now and then so beq gets taken
        prog[i] = b_type(13'(4 * step), (rand_below(4) == 0) ? rs1 : rs2, rs1,
                         3'(rand_below(2)));
      end else begin
        prog[i] = j_type(21'(4 * step), rd);
      end
    end
    prog[PROG_LEN-1] = j_type(21'd0, 5'd0);  // park here
  endtask

  task automatic run_model();
    word_t       model_regs [32];
    word_t       model_mem [256];
    word_t       inst, a, b, val, addr;
    logic [12:0] bimm;
    logic [20:0] jimm;
    logic [2:0]  f3;
    reg_addr_t   rd;
    logic        wr;
    int          idx, next_idx;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    for (int w = 0; w < 256; w++) model_mem[w] = '0;
    idx = 0;
    while (idx != PROG_LEN - 1) begin
      inst     = prog[idx];
      rd       = inst[11:7];
      f3       = inst[14:12];
      a        = model_regs[inst[19:15]];
      b        = model_regs[inst[24:20]];
      bimm     = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      jimm     = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      next_idx = idx + 1;
      wr       = 1'b1;
      val      = '0;
      case (inst[6:0])
        OPC_OP:     val = ref_alu(f3, inst[30], a, b);
        OPC_OP_IMM: val = ref_alu(f3, f3 == 3'd5 && inst[30], a, {{20{inst[31]}}, inst[31:20]});
        OPC_LUI:    val = {inst[31:12], 12'b0};
        OPC_LOAD: begin
          addr = a + {{20{inst[31]}}, inst[31:20]};
          val  = model_mem[addr[9:2]];
        end
        OPC_STORE: begin
          wr   = 1'b0;
          addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
          model_mem[addr[9:2]] = b;
        end
        OPC_BRANCH: begin
          wr = 1'b0;
          if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
            next_idx = idx + int'(bimm) / 4;  // forward offsets only
          end
        end
        OPC_JAL: begin
          val      = word_t'(idx * 4 + 4);
          next_idx = idx + int'(jimm) / 4;
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 5'd0) begin
        model_regs[rd] = val;
        exp_rd.push_back(rd);
        exp_data.push_back(val);
      end
      idx = next_idx;
    end
  endtask

  // program goes in while the core is held in reset
  task automatic load_program();
    for (int i = 0; i < PROG_LEN; i++) begin
      @(posedge clk);
      imem_load_en   <= 1'b1;
      imem_load_addr <= imem_addr_t'(i);
      imem_load_data <= prog[i];
    end
    @(posedge clk);
    imem_load_en <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin
      if (wb_valid !== 1'b0) abort_run("wb_valid is not low during reset");
    end else if (wb_valid) begin
      if (seen_count >= exp_rd.size()) begin
        abort_run($sformatf("unexpected extra writeback to x%0d", wb_rd));
      end else begin
        check_value($sformatf("writeback %0d rd", seen_count),
                    word_t'(exp_rd[seen_count]), word_t'(wb_rd));
        check_value($sformatf("writeback %0d data", seen_count),
                    exp_data[seen_count], wb_data);
        seen_count++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("watchdog expired with %0d of %0d writebacks seen",
                        seen_count, exp_rd.size()));
  end

  initial begin
    rst_n          = 1'b0;
    imem_load_en   = 1'b0;
    imem_load_addr = '0;
    imem_load_data = '0;
    build_program();
    run_model();
    load_program();
    wait (seen_count == exp_rd.size());
    repeat (QUIET_CYCLES) @(posedge clk);  // any extra writeback shows up here
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: src.f
design/rv_core_pkg.sv
design/inst_mem.sv
design/data_mem.sv
design/reg_file.sv
design/inst_decode.sv
design/alu.sv
design/execute_stage.sv
design/rv_core.sv
tb/rv_core_tb.sv

// File: Makefile
TOOL       = verilator
TOP        = rv_core_tb
FILELIST   = src.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -j 0
PASS_MSG   = Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
